// ==== uart_pkg.sv ====
package uart_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    // Offset bits inside the register window.
    localparam logic [ADDR_W-1:0] ADDR_MASK = 32'h0000_000F;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
    } bus_req_t;

    // Laid out in register bit order.
    typedef struct packed {
        logic [15:0] baud_div;  // Clock cycles per bit.
        logic [13:0] rsvd;
        logic        rx_en;
        logic        tx_en;
    } uart_ctrl_t;

    typedef struct packed {
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,
        REG_STATUS = 4'h4,
        REG_RDATA  = 4'h8,
        REG_WDATA  = 4'hC
    } reg_addr_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// ==== fifo.sv ====
`timescale 1ns/1ps

module fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 32
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr_q;  // Extra bit tells full from empty.
    logic [AW:0]      rd_ptr_q;
    logic             push_ok;
    logic             pop_ok;

    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    // Head entry falls through.
    assign data_o = mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_ok)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr_q[AW-1:0]] <= data_i;
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  uart_pkg::uart_ctrl_t ctrl_i,
    input  logic [7:0]           fifo_data_i,
    input  logic                 fifo_empty_i,
    output logic                 fifo_pop_o,
    output logic                 tx_o
);

    uart_pkg::tx_state_e state_q;
    logic [15:0]         baud_cnt_q;
    logic [2:0]          bit_idx_q;
    logic [7:0]          shift_q;
    logic                tx_q;
    logic                bit_done;
    logic                take;

    assign bit_done   = (baud_cnt_q == ctrl_i.baud_div - 16'd1);
    assign take       = (state_q == uart_pkg::TX_IDLE) && ctrl_i.tx_en && !fifo_empty_i;
    assign fifo_pop_o = take;
    assign tx_o       = tx_q;

    // ***********************************************************************
    // Frame sequencer
    // ***********************************************************************
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= uart_pkg::TX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            tx_q       <= 1'b1;  // Line idles high.
        end else begin
            baud_cnt_q <= bit_done ? 16'd0 : baud_cnt_q + 16'd1;
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (take) begin
                        state_q <= uart_pkg::TX_START;
                        tx_q    <= 1'b0;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        state_q   <= uart_pkg::TX_DATA;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= uart_pkg::TX_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            tx_q <= shift_q[0];
                        end
                    end
                end
                default: begin
                    if (bit_done) state_q <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // LSB first, so shift right as each bit goes out.
    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= fifo_data_i;
        end else if (bit_done && (state_q == uart_pkg::TX_START ||
                                  state_q == uart_pkg::TX_DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  uart_pkg::uart_ctrl_t ctrl_i,
    input  logic                 rx_i,
    output logic [7:0]           rx_data_o,
    output logic                 rx_valid_o
);

    uart_pkg::rx_state_e state_q;
    logic        rx_s1_q;
    logic        rx_s2_q;
    logic        rx_d_q;  // Previous synchronized level.
    logic [15:0] baud_cnt_q;
    logic [2:0]  bit_idx_q;
    logic [7:0]  shift_q;
    logic        valid_q;
    logic        fall;
    logic        bit_done;
    logic        half_done;

    assign fall      = rx_d_q && !rx_s2_q;
    assign bit_done  = (baud_cnt_q == ctrl_i.baud_div - 16'd1);
    assign half_done = (baud_cnt_q == {1'b0, ctrl_i.baud_div[15:1]} - 16'd1);

    assign rx_data_o  = shift_q;
    assign rx_valid_o = valid_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_s1_q <= 1'b1;
            rx_s2_q <= 1'b1;
            rx_d_q  <= 1'b1;
        end else begin
            rx_s1_q <= rx_i;
            rx_s2_q <= rx_s1_q;
            rx_d_q  <= rx_s2_q;
        end
    end

    // ***********************************************************************
    // Bit-centre sampler
    // ***********************************************************************
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= uart_pkg::RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q    <= 1'b0;
            baud_cnt_q <= baud_cnt_q + 16'd1;
            case (state_q)
                uart_pkg::RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (fall) state_q <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: begin
                    if (half_done) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= '0;
                        // Glitch if the line is back high at mid start bit.
                        state_q <= rx_s2_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_done) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) state_q <= uart_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state_q <= uart_pkg::RX_IDLE;
                        valid_q <= rx_s2_q && ctrl_i.rx_en;  // Good stop bit only.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == uart_pkg::RX_DATA && bit_done) begin
            shift_q <= {rx_s2_q, shift_q[7:1]};
        end
    end

endmodule

// ==== uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs #(
    parameter logic [31:0] BASE_ADDR = 32'h2000_0000
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  logic                 req_valid_i,
    input  uart_pkg::bus_req_t   req_i,
    output logic                 req_ready_o,

    output logic                 resp_valid_o,
    output logic [31:0]          resp_data_o,
    input  logic                 resp_ready_i,

    output uart_pkg::uart_ctrl_t ctrl_o,

    output logic                 txf_push_o,
    output logic [7:0]           txf_data_o,
    input  logic                 txf_full_i,
    input  logic                 txf_empty_i,

    output logic                 rxf_pop_o,
    input  logic [7:0]           rxf_data_i,
    input  logic                 rxf_full_i,
    input  logic                 rxf_empty_i
);

    uart_pkg::uart_ctrl_t   ctrl_q;
    uart_pkg::uart_status_t status;
    uart_pkg::reg_addr_e    offset;
    logic                   accept;
    logic                   hit;
    logic                   ctrl_we;
    logic [31:0]            resp_d;
    logic                   resp_valid_q;
    logic [31:0]            resp_data_q;

    assign accept = req_valid_i && req_ready_o;
    assign hit    = ((req_i.addr & ~uart_pkg::ADDR_MASK) == BASE_ADDR);
    assign offset = uart_pkg::reg_addr_e'(req_i.addr[3:0]);

    assign status.rx_empty = rxf_empty_i;
    assign status.rx_full  = rxf_full_i;
    assign status.tx_empty = txf_empty_i;
    assign status.tx_full  = txf_full_i;

    // ***********************************************************************
    // Decode and side effects of an accepted request
    // ***********************************************************************
    always_comb begin
        resp_d     = '0;
        ctrl_we    = 1'b0;
        txf_push_o = 1'b0;
        rxf_pop_o  = 1'b0;
        if (accept && hit) begin
            case (offset)
                uart_pkg::REG_CTRL: begin
                    if (req_i.write) ctrl_we = 1'b1;
                    else             resp_d  = ctrl_q;
                end
                uart_pkg::REG_STATUS: begin
                    if (!req_i.write) resp_d = {28'd0, status};
                end
                uart_pkg::REG_RDATA: begin
                    if (!req_i.write && !rxf_empty_i) begin
                        rxf_pop_o = 1'b1;
                        resp_d    = {24'd0, rxf_data_i};
                    end
                end
                uart_pkg::REG_WDATA: begin
                    txf_push_o = req_i.write && !txf_full_i;  // Full drops the byte.
                end
                default: ;
            endcase
        end
    end

    assign txf_data_o = req_i.wdata[7:0];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ctrl_q       <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            if (ctrl_we) ctrl_q <= uart_pkg::uart_ctrl_t'(req_i.wdata);
            if (accept)            resp_valid_q <= 1'b1;
            else if (resp_ready_i) resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) resp_data_q <= resp_d;
    end

    // One request in flight at a time.
    assign req_ready_o  = !resp_valid_q;
    assign resp_valid_o = resp_valid_q;
    assign resp_data_o  = resp_data_q;
    assign ctrl_o       = ctrl_q;

endmodule

// ==== uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
    parameter logic [31:0] BASE_ADDR  = 32'h2000_0000,
    parameter int          FIFO_DEPTH = 32
) (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic               req_valid_i,
    input  uart_pkg::bus_req_t req_i,
    output logic               req_ready_o,

    output logic               resp_valid_o,
    output logic [31:0]        resp_data_o,
    input  logic               resp_ready_i,

    input  logic               rx_i,
    output logic               tx_o
);

    uart_pkg::uart_ctrl_t ctrl;

    // Transmit FIFO.
    logic       txf_push;
    logic [7:0] txf_wdata;
    logic       txf_pop;
    logic [7:0] txf_rdata;
    logic       txf_full;
    logic       txf_empty;

    // Receive FIFO.
    logic       rxf_pop;
    logic [7:0] rxf_rdata;
    logic       rxf_full;
    logic       rxf_empty;
    logic [7:0] rx_data;
    logic       rx_valid;

    uart_regs #(
        .BASE_ADDR (BASE_ADDR)
    ) u_regs (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .resp_ready_i (resp_ready_i),
        .ctrl_o       (ctrl),
        .txf_push_o   (txf_push),
        .txf_data_o   (txf_wdata),
        .txf_full_i   (txf_full),
        .txf_empty_i  (txf_empty),
        .rxf_pop_o    (rxf_pop),
        .rxf_data_i   (rxf_rdata),
        .rxf_full_i   (rxf_full),
        .rxf_empty_i  (rxf_empty)
    );

    fifo #(.WIDTH(8), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (txf_push),
        .data_i  (txf_wdata),
        .pop_i   (txf_pop),
        .data_o  (txf_rdata),
        .full_o  (txf_full),
        .empty_o (txf_empty)
    );

    // A byte that finds the FIFO full is lost.
    fifo #(.WIDTH(8), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (rx_valid && !rxf_full),
        .data_i  (rx_data),
        .pop_i   (rxf_pop),
        .data_o  (rxf_rdata),
        .full_o  (rxf_full),
        .empty_o (rxf_empty)
    );

    uart_tx u_tx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ctrl_i       (ctrl),
        .fifo_data_i  (txf_rdata),
        .fifo_empty_i (txf_empty),
        .fifo_pop_o   (txf_pop),
        .tx_o         (tx_o)
    );

    uart_rx u_rx (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ctrl_i     (ctrl),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

endmodule

// ==== tb_uart_asserts.sv ====
`timescale 1ns/1ps

module tb_uart_asserts (
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  tx_i,
    input uart_pkg::tx_state_e   tx_state_i,
    input logic                  resp_valid_i,
    input logic [31:0]           resp_data_i,
    input logic                  resp_ready_i,
    input logic                  txf_push_i,
    input logic                  txf_full_i
);

    // Serial line rests high between frames.
    a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (tx_state_i == uart_pkg::TX_IDLE) |-> tx_i)
        else $error("tx_o is low while the transmitter is idle");

    a_resp_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_data_i)))
        else $error("response changed while held by back-pressure");

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        txf_full_i |-> !txf_push_i)
        else $error("transmit FIFO pushed while full");

endmodule

bind uart_top tb_uart_asserts u_asserts (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .tx_i         (tx_o),
    .tx_state_i   (u_tx.state_q),
    .resp_valid_i (resp_valid_o),
    .resp_data_i  (resp_data_o),
    .resp_ready_i (resp_ready_i),
    .txf_push_i   (txf_push),
    .txf_full_i   (txf_full)
);

// ==== tb_uart.sv ====
`timescale 1ns/1ps

module tb_uart;

    localparam int          BAUD       = 8;
    localparam int          FIFO_DEPTH = 32;
    localparam logic [31:0] A_CTRL     = 32'h2000_0000;
    localparam logic [31:0] A_STATUS   = 32'h2000_0004;
    localparam logic [31:0] A_RDATA    = 32'h2000_0008;
    localparam logic [31:0] A_WDATA    = 32'h2000_000C;
    localparam logic [31:0] CTRL_ON    = {16'(BAUD), 14'd0, 1'b1, 1'b1};
    localparam logic [31:0] CTRL_TX    = {16'(BAUD), 14'd0, 1'b0, 1'b1};
    localparam logic [31:0] CTRL_OFF   = {16'(BAUD), 16'd0};

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_SEND, OP_SEND_BAD, OP_EXPECT, OP_WAIT, OP_NO_TX
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic               clk_i;
    logic               rstn_i;
    logic               req_valid_i;
    uart_pkg::bus_req_t req_i;
    logic               req_ready_o;
    logic               resp_valid_o;
    logic [31:0]        resp_data_o;
    logic               resp_ready_i;
    logic               rx_i;
    logic               tx_o;

    step_t      steps[$];
    logic [7:0] tx_bytes_q[$];  // Bytes seen on tx_o.
    int         cycles;
    int         cycle_limit;

    uart_top u_dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .resp_ready_i (resp_ready_i),
        .rx_i         (rx_i),
        .tx_o         (tx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic void add_step(input op_e op, input logic [31:0] addr,
                                     input logic [31:0] data, input logic [31:0] exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endfunction

    // ***********************************************************************
    // Stimulus table
    // ***********************************************************************
    function automatic void build_steps();
        logic [7:0] b [FIFO_DEPTH+1];
        add_step(OP_READ, A_STATUS, 32'd0, 32'hA);  // Both FIFOs empty.
        add_step(OP_WRITE, A_CTRL, CTRL_ON, 32'd0);
        add_step(OP_READ, A_CTRL, 32'd0, CTRL_ON);
        add_step(OP_READ, 32'h3000_0004, 32'd0, 32'd0);
        add_step(OP_WRITE, 32'h1000_0000, 32'hFFFF_FFFF, 32'd0);
        add_step(OP_READ, A_CTRL, 32'd0, CTRL_ON);
        // Transmit.
        for (int i = 0; i < 4; i++) begin
            b[i] = 8'($urandom_range(0, 255));
            add_step(OP_WRITE, A_WDATA, {24'd0, b[i]}, 32'd0);
        end
        for (int i = 0; i < 4; i++) add_step(OP_EXPECT, 32'd0, 32'd0, {24'd0, b[i]});
        // Receive.
        for (int i = 0; i < 4; i++) begin
            b[i] = 8'($urandom_range(0, 255));
            add_step(OP_SEND, 32'd0, {24'd0, b[i]}, 32'd0);
        end
        for (int i = 0; i < 4; i++) add_step(OP_READ, A_RDATA, 32'd0, {24'd0, b[i]});
        add_step(OP_READ, A_RDATA, 32'd0, 32'd0);
        add_step(OP_READ, A_STATUS, 32'd0, 32'hA);
        // Bad stop bit, then a frame with the receiver off.
        add_step(OP_SEND_BAD, 32'd0, 32'($urandom_range(1, 255)), 32'd0);
        add_step(OP_READ, A_RDATA, 32'd0, 32'd0);
        add_step(OP_WRITE, A_CTRL, CTRL_OFF, 32'd0);
        add_step(OP_SEND, 32'd0, 32'($urandom_range(1, 255)), 32'd0);
        add_step(OP_READ, A_RDATA, 32'd0, 32'd0);
        // Overfill the transmit FIFO; the last byte is dropped.
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            b[i] = 8'($urandom_range(0, 255));
            add_step(OP_WRITE, A_WDATA, {24'd0, b[i]}, 32'd0);
        end
        add_step(OP_READ, A_STATUS, 32'd0, 32'h9);
        add_step(OP_WRITE, A_CTRL, CTRL_TX, 32'd0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_step(OP_EXPECT, 32'd0, 32'd0, {24'd0, b[i]});
        end
        add_step(OP_WAIT, 32'd0, 32'(3 * 10 * BAUD), 32'd0);
        add_step(OP_NO_TX, 32'd0, 32'd0, 32'd0);
        add_step(OP_READ, A_STATUS, 32'd0, 32'hA);
    endfunction

    // One request, then its response under random back-pressure.
    task automatic bus_xfer(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        logic done;
        req_valid_i = 1'b1;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        req_i.write = write;
        @(negedge clk_i);
        while (!req_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        done = 1'b0;
        while (!done) begin
            resp_ready_i = ($urandom_range(0, 2) != 0);
            @(negedge clk_i);
            check_value("resp_valid_o", 32'd1, {31'd0, resp_valid_o});
            check_value("req_ready_o", 32'd0, {31'd0, req_ready_o});
            if (resp_ready_i) begin
                done  = 1'b1;
                rdata = resp_data_o;
            end
            @(posedge clk_i);
            #1;
        end
        resp_ready_i = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_i = bits[i];
            repeat (BAUD) @(posedge clk_i);
            #1;
        end
        rx_i = 1'b1;  // One idle bit.
        repeat (BAUD) @(posedge clk_i);
        #1;
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] rdata;
        case (s.op)
            OP_WRITE: begin
                bus_xfer(1'b1, s.addr, s.data, rdata);
                check_value("resp_data_o", 32'd0, rdata);
            end
            OP_READ: begin
                bus_xfer(1'b0, s.addr, 32'd0, rdata);
                check_value("resp_data_o", s.exp, rdata);
            end
            OP_SEND:     send_frame(s.data[7:0], 1'b1);
            OP_SEND_BAD: send_frame(s.data[7:0], 1'b0);
            OP_EXPECT: begin
                while (tx_bytes_q.size() == 0) begin
                    @(posedge clk_i);
                    #1;
                end
                check_value("tx_o byte", s.exp, {24'd0, tx_bytes_q.pop_front()});
            end
            OP_WAIT: begin
                repeat (s.data) @(posedge clk_i);
                #1;
            end
            default: check_value("tx_o byte count", 32'd0, 32'(tx_bytes_q.size()));
        endcase
    endtask

    // Serial decoder; samples tx_o at bit centres on falling clock edges.
    initial begin : tx_decoder
        logic       prev;
        logic [7:0] b;
        prev = 1'b1;
        forever begin
            @(negedge clk_i);
            if (rstn_i && prev && !tx_o) begin
                repeat (BAUD / 2) @(negedge clk_i);
                check_value("tx_o start bit", 32'd0, {31'd0, tx_o});
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD) @(negedge clk_i);
                    b[i] = tx_o;
                end
                repeat (BAUD) @(negedge clk_i);
                check_value("tx_o stop bit", 32'd1, {31'd0, tx_o});
                tx_bytes_q.push_back(b);
            end
            prev = tx_o;
        end
    end

    initial begin : watchdog
        cycles = 0;
        wait (cycle_limit != 0);
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("Timed out after %0d cycles without finishing the tests", cycles);
                $display("Simulation failed");
                $fatal(1);
            end
        end
    end

    initial begin : main
        int frames;
        int waits;
        cycle_limit  = 0;
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        rx_i         = 1'b1;
        void'($urandom(51867));
        build_steps();
        frames = 0;
        waits  = 0;
        foreach (steps[k]) begin
            if (steps[k].op inside {OP_SEND, OP_SEND_BAD, OP_EXPECT}) frames++;
            if (steps[k].op == OP_WAIT) waits += int'(steps[k].data);
        end
        cycle_limit = frames * 10 * BAUD + 200 * steps.size() + waits;
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        foreach (steps[k]) apply_step(steps[k]);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
uart_pkg.sv
fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_uart_asserts.sv
tb_uart.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := tb_uart
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
